// File: common/lenet_ctrl_pkg.sv
package lenet_ctrl_pkg;

    // window tracking.
    typedef enum logic {
        ST_IDLE,  // no window open.
        ST_ACCUM  // taps of a window are being taken.
    } conv_state_t;

    // 5x5 kernel.
    localparam int KERNEL_TAPS_DEFAULT = 25;

endpackage

// File: common/lenet_data_pkg.sv
package lenet_data_pkg;

    // activation from the feature map, unsigned.
    typedef logic [7:0] act_t;

    // kernel weight, unsigned.
    typedef logic [7:0] weight_t;

    // approximate 8x8 product.
    typedef logic [15:0] product_t;

    // 25 products of 255*255 need 21 bits, so 24 leaves headroom.
    localparam int ACC_W_DEFAULT = 24;

endpackage

// File: flist.f
common/lenet_data_pkg.sv
common/lenet_ctrl_pkg.sv
mac/lenet_approx_mul.sv
mac/lenet_mac_lane.sv
source/lenet_weight_store.sv
source/lenet_conv_ctrl.sv
source/lenet_conv_top.sv
tests/lenet_conv_checker.sv
tests/lenet_conv_tb.sv

// File: mac/lenet_approx_mul.sv
`timescale 1ns/100ps

module lenet_approx_mul (
    input  lenet_data_pkg::act_t     x,
    input  lenet_data_pkg::weight_t  y,
    output lenet_data_pkg::product_t z
);

    // one partial product row per activation bit.
    logic [7:0] pp0;
    logic [7:0] pp1;
    logic [7:0] pp2;
    logic [7:0] pp3;
    logic [7:0] pp4;
    logic [7:0] pp5;
    logic [7:0] pp6;
    logic [7:0] pp7;

    // rows 0 to 5 folded into six compressed words.
    logic [12:0] cw0;
    logic [12:0] cw1;
    logic [12:0] cw2;
    logic [12:0] cw3;
    logic [12:0] cw4;
    logic [12:0] cw5;

    assign pp0 = y & {8{x[0]}};
    assign pp1 = y & {8{x[1]}};
    assign pp2 = y & {8{x[2]}};
    assign pp3 = y & {8{x[3]}};
    assign pp4 = y & {8{x[4]}};
    assign pp5 = y & {8{x[5]}};
    assign pp6 = y & {8{x[6]}};
    assign pp7 = y & {8{x[7]}};

    // each bit pairs neighbouring rows; bits not listed stay zero.
    always_comb begin
        cw0 = '0;
        cw1 = '0;
        cw2 = '0;
        cw3 = '0;
        cw4 = '0;
        cw5 = '0;

        cw0[1]  = pp0[1] | pp1[0];
        cw0[2]  = pp0[1] | pp1[0];  // same pair as bit 1, as characterised.
        cw0[3]  = pp0[3] | pp1[2];
        cw0[5]  = pp2[2] & pp3[1];
        cw0[7]  = pp4[2] | pp5[1];
        cw0[8]  = pp0[7] | pp1[6];
        cw0[9]  = pp2[7] | pp3[6];
        cw0[10] = pp2[7] & pp3[6];
        cw0[11] = pp4[7] & pp5[6];
        cw0[12] = pp5[7];

        cw1[2]  = pp0[2] | pp1[1];
        cw1[3]  = pp2[1] | pp3[0];
        cw1[7]  = pp4[3] ^ pp5[2];
        cw1[8]  = pp1[7];
        cw1[9]  = pp4[4] & pp5[3];
        cw1[10] = pp3[7];
        cw1[11] = pp4[7] | pp5[6];

        cw2[8]  = pp2[5] | pp3[4];
        cw2[9]  = pp4[5] ^ pp5[4];
        cw2[10] = pp4[5] & pp5[4];

        cw3[8]  = pp2[6] | pp3[5];
        cw3[10] = pp4[6] & pp5[5];

        cw4[8]  = pp4[3] & pp5[2];
        cw4[10] = pp4[6] | pp5[5];

        cw5[8]  = pp4[4] ^ pp5[3];
    end

    // exact top rows plus the compressed words, wrapping at 16 bits.
    assign z = lenet_data_pkg::product_t'({pp6, 6'b0})
             + lenet_data_pkg::product_t'({pp7, 7'b0})
             + lenet_data_pkg::product_t'(cw0)
             + lenet_data_pkg::product_t'(cw1)
             + lenet_data_pkg::product_t'(cw2)
             + lenet_data_pkg::product_t'(cw3)
             + lenet_data_pkg::product_t'(cw4)
             + lenet_data_pkg::product_t'(cw5);

endmodule

// File: mac/lenet_mac_lane.sv
`timescale 1ns/100ps

module lenet_mac_lane #(
    parameter int ACC_W = lenet_data_pkg::ACC_W_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mac_en,
    input  logic                    first_tap,
    input  logic                    last_tap,
    input  lenet_data_pkg::act_t    pixel,
    input  lenet_data_pkg::weight_t tap_weight,
    output logic                    result_valid,
    output logic [ACC_W-1:0]        result
);

    lenet_data_pkg::product_t prod;
    lenet_data_pkg::product_t prod_q;
    logic                     valid_q;
    logic                     first_q;
    logic                     last_q;
    logic [ACC_W-1:0]         acc;
    logic [ACC_W-1:0]         acc_next;

    lenet_approx_mul lenet_approx_mul_i (
        .x (pixel),
        .y (tap_weight),
        .z (prod)
    );

    // stage 1 product register, only loaded on a tap.
    always_ff @(posedge clk) begin
        if (mac_en) begin
            prod_q <= prod;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= mac_en;
            if (mac_en) begin
                first_q <= first_tap;
                last_q  <= last_tap;
            end
        end
    end

    // a first tap restarts the sum instead of adding to the old window.
    assign acc_next = first_q ? ACC_W'(prod_q) : acc + ACC_W'(prod_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc          <= '0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid_q && last_q;
            if (valid_q) begin
                acc <= acc_next;
            end
            if (valid_q && last_q) begin
                result <= acc_next;  // held until the next window closes.
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f flist.f \
    --top-module lenet_conv_tb \
    -Mdir obj_dir \
    -o lenet_conv_sim

./obj_dir/lenet_conv_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "All tests passed" "$LOG"; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi

// File: source/lenet_conv_ctrl.sv
`timescale 1ns/100ps

module lenet_conv_ctrl #(
    parameter int KERNEL_TAPS = lenet_ctrl_pkg::KERNEL_TAPS_DEFAULT,
    localparam int TAP_W      = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pixel_valid,
    output logic [TAP_W-1:0] tap_index,
    output logic             mac_en,
    output logic             first_tap,
    output logic             last_tap
);

    localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(KERNEL_TAPS - 1);

    lenet_ctrl_pkg::conv_state_t state;
    lenet_ctrl_pkg::conv_state_t state_next;
    logic [TAP_W-1:0]            tap_cnt;
    logic [TAP_W-1:0]            tap_cnt_next;

    assign tap_index = tap_cnt;
    assign mac_en    = pixel_valid;
    assign first_tap = pixel_valid && (tap_cnt == '0);
    assign last_tap  = pixel_valid && (tap_cnt == LAST_TAP);

    always_comb begin
        state_next   = state;
        tap_cnt_next = tap_cnt;
        case (state)
            lenet_ctrl_pkg::ST_IDLE: begin
                if (pixel_valid) begin
                    // a one tap kernel closes on the same strobe.
                    state_next   = last_tap ? lenet_ctrl_pkg::ST_IDLE
                                            : lenet_ctrl_pkg::ST_ACCUM;
                    tap_cnt_next = last_tap ? '0 : tap_cnt + 1'b1;
                end
            end
            lenet_ctrl_pkg::ST_ACCUM: begin
                if (pixel_valid) begin
                    if (last_tap) begin
                        state_next   = lenet_ctrl_pkg::ST_IDLE;
                        tap_cnt_next = '0;
                    end else begin
                        tap_cnt_next = tap_cnt + 1'b1;
                    end
                end
            end
            default: begin
                state_next   = lenet_ctrl_pkg::ST_IDLE;
                tap_cnt_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= lenet_ctrl_pkg::ST_IDLE;
            tap_cnt <= '0;
        end else begin
            state   <= state_next;
            tap_cnt <= tap_cnt_next;
        end
    end

endmodule

// File: source/lenet_conv_top.sv
`timescale 1ns/100ps

module lenet_conv_top #(
    parameter int KERNEL_TAPS = lenet_ctrl_pkg::KERNEL_TAPS_DEFAULT,
    parameter int ACC_W       = lenet_data_pkg::ACC_W_DEFAULT,
    localparam int TAP_W      = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    weight_wr,
    input  logic [TAP_W-1:0]        weight_addr,
    input  lenet_data_pkg::weight_t weight_data,
    input  logic                    pixel_valid,
    input  lenet_data_pkg::act_t    pixel,
    output logic                    result_valid,
    output logic [ACC_W-1:0]        result
);

    logic [TAP_W-1:0]        tap_index;
    lenet_data_pkg::weight_t tap_weight;
    logic                    mac_en;
    logic                    first_tap;
    logic                    last_tap;

    lenet_conv_ctrl #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) lenet_conv_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .tap_index   (tap_index),
        .mac_en      (mac_en),
        .first_tap   (first_tap),
        .last_tap    (last_tap)
    );

    lenet_weight_store #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) lenet_weight_store_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_wr   (weight_wr),
        .weight_addr (weight_addr),
        .weight_data (weight_data),
        .tap_index   (tap_index),
        .tap_weight  (tap_weight)
    );

    // activation bypasses the controller and meets its weight in the lane.
    lenet_mac_lane #(
        .ACC_W (ACC_W)
    ) lenet_mac_lane_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mac_en       (mac_en),
        .first_tap    (first_tap),
        .last_tap     (last_tap),
        .pixel        (pixel),
        .tap_weight   (tap_weight),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: source/lenet_weight_store.sv
`timescale 1ns/100ps

module lenet_weight_store #(
    parameter int KERNEL_TAPS = lenet_ctrl_pkg::KERNEL_TAPS_DEFAULT,
    localparam int TAP_W      = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    weight_wr,
    input  logic [TAP_W-1:0]        weight_addr,
    input  lenet_data_pkg::weight_t weight_data,
    input  logic [TAP_W-1:0]        tap_index,
    output lenet_data_pkg::weight_t tap_weight
);

    lenet_data_pkg::weight_t weights [KERNEL_TAPS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < KERNEL_TAPS; i++) begin
                weights[i] <= '0;
            end
        end else if (weight_wr && (weight_addr < KERNEL_TAPS)) begin
            weights[weight_addr] <= weight_data;  // out of range writes dropped.
        end
    end

    // unused codes of a non power of two index read as zero.
    assign tap_weight = (tap_index < KERNEL_TAPS) ? weights[tap_index] : '0;

endmodule

// File: tests/lenet_conv_checker.sv
`timescale 1ns/100ps

module lenet_conv_checker #(
    parameter int KERNEL_TAPS = 25,
    parameter int ACC_W       = 24,
    localparam int TAP_W      = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    weight_wr,
    input  logic [TAP_W-1:0]        weight_addr,
    input  lenet_data_pkg::weight_t weight_data,
    input  logic                    pixel_valid,
    input  lenet_data_pkg::act_t    pixel,
    input  logic                    result_valid,
    input  logic [ACC_W-1:0]        result,
    output int                      error_count,
    output int                      result_count,
    output int                      pending
);

    lenet_data_pkg::weight_t weights [KERNEL_TAPS];
    logic [ACC_W-1:0]        exp_sum [$];
    int                      last_cycle [$];
    logic [ACC_W-1:0]        acc;
    logic [15:0]             prod;
    int                      tap = 0;
    int                      cycle = 0;
    int                      errors = 0;
    int                      results = 0;
    int                      n_pending = 0;

    assign error_count  = errors;
    assign result_count = results;
    assign pending      = n_pending;

    // approximate product rule: exact rows 6 and 7, rows 0 to 5 folded pairwise.
    function automatic logic [15:0] approx_product(logic [7:0] a, logic [7:0] w);
        logic [7:0]  pp [8];
        logic [12:0] cw [6];
        logic [15:0] sum;
        for (int i = 0; i < 8; i++) begin
            pp[i] = w & {8{a[i]}};
        end
        for (int i = 0; i < 6; i++) begin
            cw[i] = '0;
        end
        cw[0][1]  = pp[0][1] | pp[1][0];
        cw[0][2]  = pp[0][1] | pp[1][0];
        cw[0][3]  = pp[0][3] | pp[1][2];
        cw[0][5]  = pp[2][2] & pp[3][1];
        cw[0][7]  = pp[4][2] | pp[5][1];
        cw[0][8]  = pp[0][7] | pp[1][6];
        cw[0][9]  = pp[2][7] | pp[3][6];
        cw[0][10] = pp[2][7] & pp[3][6];
        cw[0][11] = pp[4][7] & pp[5][6];
        cw[0][12] = pp[5][7];
        cw[1][2]  = pp[0][2] | pp[1][1];
        cw[1][3]  = pp[2][1] | pp[3][0];
        cw[1][7]  = pp[4][3] ^ pp[5][2];
        cw[1][8]  = pp[1][7];
        cw[1][9]  = pp[4][4] & pp[5][3];
        cw[1][10] = pp[3][7];
        cw[1][11] = pp[4][7] | pp[5][6];
        cw[2][8]  = pp[2][5] | pp[3][4];
        cw[2][9]  = pp[4][5] ^ pp[5][4];
        cw[2][10] = pp[4][5] & pp[5][4];
        cw[3][8]  = pp[2][6] | pp[3][5];
        cw[3][10] = pp[4][6] & pp[5][5];
        cw[4][8]  = pp[4][3] & pp[5][2];
        cw[4][10] = pp[4][6] | pp[5][5];
        cw[5][8]  = pp[4][4] ^ pp[5][3];
        sum = 16'({pp[6], 6'b0}) + 16'({pp[7], 7'b0});
        for (int i = 0; i < 6; i++) begin
            sum = sum + 16'(cw[i]);
        end
        return sum;
    endfunction

    always @(posedge clk) begin
        cycle++;
        if (!rst_n) begin
            for (int i = 0; i < KERNEL_TAPS; i++) begin
                weights[i] = '0;
            end
            tap = 0;
            acc = '0;
            exp_sum.delete();
            last_cycle.delete();
        end else begin
            if (result_valid) begin
                if (exp_sum.size() == 0) begin
                    $display("extra result pulse at %0t with no window closed", $time);
                    errors++;
                end else begin
                    if (cycle != last_cycle[0] + 2) begin
                        $display("result pulse at %0t came %0d cycles after the last tap, not 2",
                                 $time, cycle - last_cycle[0]);
                        errors++;
                    end
                    if (result !== exp_sum[0]) begin
                        $display("** Error at %0t: result expected %0d, got %0d",
                                 $time, exp_sum[0], result);
                        errors++;
                    end
                    results++;
                    void'(exp_sum.pop_front());
                    void'(last_cycle.pop_front());
                end
            end else if (exp_sum.size() != 0 && cycle > last_cycle[0] + 2) begin
                $display("no result pulse 2 cycles after the last tap, seen at %0t", $time);
                errors++;
                void'(exp_sum.pop_front());
                void'(last_cycle.pop_front());
            end
            // taps of this edge still see the old weights.
            if (pixel_valid) begin
                prod = approx_product(pixel, weights[tap]);
                acc  = (tap == 0) ? ACC_W'(prod) : acc + ACC_W'(prod);
                if (tap == KERNEL_TAPS - 1) begin
                    exp_sum.push_back(acc);
                    last_cycle.push_back(cycle);
                    tap = 0;
                end else begin
                    tap++;
                end
            end
            if (weight_wr && weight_addr < KERNEL_TAPS) begin
                weights[weight_addr] = weight_data;
            end
        end
        n_pending = exp_sum.size();
    end

endmodule

// File: tests/lenet_conv_tb.sv
`timescale 1ns/100ps

module lenet_conv_tb;

    localparam int TAPS  = 25;
    localparam int ACC_W = 24;
    localparam int TAP_W = $clog2(TAPS);

    logic                    clk;
    logic                    rst_n;
    logic                    weight_wr;
    logic [TAP_W-1:0]        weight_addr;
    lenet_data_pkg::weight_t weight_data;
    logic                    pixel_valid;
    lenet_data_pkg::act_t    pixel;
    logic                    result_valid;
    logic [ACC_W-1:0]        result;
    int                      error_count;
    int                      result_count;
    int                      pending;

    logic [15:0]             lfsr_state = 16'd28040;
    lenet_data_pkg::weight_t wt [TAPS];
    lenet_data_pkg::act_t    act [TAPS];
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      tb_errors = 0;
    int                      errors_at_start;
    int                      results_at_start;

    lenet_conv_top #(
        .KERNEL_TAPS (TAPS),
        .ACC_W       (ACC_W)
    ) lenet_conv_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .weight_wr    (weight_wr),
        .weight_addr  (weight_addr),
        .weight_data  (weight_data),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .result_valid (result_valid),
        .result       (result)
    );

    lenet_conv_checker #(
        .KERNEL_TAPS (TAPS),
        .ACC_W       (ACC_W)
    ) lenet_conv_checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .weight_wr    (weight_wr),
        .weight_addr  (weight_addr),
        .weight_data  (weight_data),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .result_valid (result_valid),
        .result       (result),
        .error_count  (error_count),
        .result_count (result_count),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        pixel_valid <= 1'b0;
        weight_wr   <= 1'b0;
    endtask

    task automatic drive_tap(lenet_data_pkg::act_t a);
        @(posedge clk);
        pixel_valid <= 1'b1;
        pixel       <= a;
        weight_wr   <= 1'b0;
    endtask

    task automatic write_weight(int addr, lenet_data_pkg::weight_t d);
        @(posedge clk);
        pixel_valid <= 1'b0;
        weight_wr   <= 1'b1;
        weight_addr <= TAP_W'(addr);
        weight_data <= d;
    endtask

    task automatic load_weights();
        for (int i = 0; i < TAPS; i++) begin
            write_weight(i, wt[i]);
        end
        drive_idle();
    endtask

    task automatic send_window(bit gaps);
        for (int i = 0; i < TAPS; i++) begin
            if (gaps && take_bits(2) == 0) begin
                repeat (take_bits(2) + 1) drive_idle();
            end
            drive_tap(act[i]);
        end
    endtask

    task automatic wait_results();
        int i;
        i = 0;
        @(negedge clk);
        while (pending != 0 && i < 50) begin
            @(negedge clk);
            i++;
        end
        if (pending != 0) begin
            $display("timeout at %0t: %0d window results still outstanding", $time, pending);
            tb_errors++;
        end
    endtask

    task automatic expect_zero_result();
        if (result !== '0) begin
            $display("** Error at %0t: result expected 0, got %0d", $time, result);
            tb_errors++;
        end
    endtask

    task automatic start_test();
        errors_at_start  = error_count + tb_errors;
        results_at_start = result_count;
    endtask

    task automatic end_test(string name, int exp_results);
        int got;
        int errs;
        wait_results();
        repeat (4) @(negedge clk);  // room for a stray pulse.
        got = result_count - results_at_start;
        if (got != exp_results) begin
            $display("%s: expected %0d window results, saw %0d", name, exp_results, got);
            tb_errors++;
        end
        errs = error_count + tb_errors - errors_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s passed with %0d results", name, got);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        weight_wr   = 1'b0;
        weight_addr = '0;
        weight_data = '0;
        pixel_valid = 1'b0;
        pixel       = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        drive_idle();

        // full-scale corner in the first five taps.
        start_test();
        for (int i = 0; i < TAPS; i++) begin
            wt[i]  = (i < 5) ? 8'd255 : 8'(i * 37 + 11);
            act[i] = (i < 5) ? 8'd255 : 8'(i * 53 + 7);
        end
        load_weights();
        send_window(1'b0);
        drive_idle();
        end_test("single window", 1);

        start_test();
        for (int i = 0; i < TAPS; i++) begin
            wt[i]  = '0;
            act[i] = 8'(take_bits(8));
        end
        load_weights();
        send_window(1'b0);
        drive_idle();
        wait_results();
        expect_zero_result();
        for (int i = 0; i < TAPS; i++) begin
            wt[i]  = 8'(take_bits(8));
            act[i] = '0;
        end
        load_weights();
        send_window(1'b0);
        drive_idle();
        wait_results();
        expect_zero_result();
        end_test("zero cases", 2);

        start_test();
        for (int w = 0; w < 3; w++) begin
            for (int i = 0; i < TAPS; i++) begin
                act[i] = 8'(take_bits(8));
            end
            send_window(1'b0);
        end
        drive_idle();
        end_test("back to back windows", 3);

        start_test();
        for (int i = 0; i < TAPS; i++) begin
            wt[i] = 8'(take_bits(8));
        end
        load_weights();
        for (int w = 0; w < 4; w++) begin
            for (int i = 0; i < TAPS; i++) begin
                act[i] = 8'(take_bits(8));
            end
            send_window(1'b1);
        end
        drive_idle();
        end_test("gapped random stream", 4);

        start_test();
        for (int i = 0; i < TAPS; i++) begin
            act[i] = 8'(take_bits(8));
            wt[i]  = 8'(take_bits(8));
        end
        load_weights();
        send_window(1'b0);
        drive_idle();
        for (int i = 0; i < TAPS; i++) begin
            wt[i] = 8'd255 - wt[i];
        end
        load_weights();
        send_window(1'b0);
        for (int i = 0; i < TAPS; i++) begin
            drive_tap(act[i]);
            if (i == 12) begin
                write_weight(20, 8'h5a);
                write_weight(27, 8'hff);  // outside the kernel.
            end
        end
        drive_idle();
        end_test("weight rewrite", 3);

        start_test();
        for (int i = 0; i < TAPS; i++) begin
            wt[i] = 8'(take_bits(8));
        end
        load_weights();
        for (int i = 0; i < 10; i++) begin
            drive_tap(8'(take_bits(8)));
        end
        @(posedge clk);
        rst_n       <= 1'b0;
        pixel_valid <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        drive_idle();
        // only two taps get weights, the rest must read back as cleared.
        write_weight(0, 8'd200);
        write_weight(24, 8'd99);
        drive_idle();
        for (int i = 0; i < TAPS; i++) begin
            act[i] = 8'(take_bits(8));
        end
        send_window(1'b0);
        drive_idle();
        end_test("reset mid window", 1);

        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, error_count + tb_errors);
        if (tests_failed == 0 && error_count + tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
